// ==== rv32i_pkg.sv ====
package rv32i_pkg;

    localparam int xlen = 32;

    typedef logic [4:0] reg_idx_t;

    // major opcodes of the supported subset.
    typedef enum logic [6:0] {
        opc_reg   = 7'b0110011,
        opc_imm   = 7'b0010011,
        opc_load  = 7'b0000011,
        opc_store = 7'b0100011
    } opcode_t;

    typedef enum logic [3:0] {
        op_add,
        op_sub,
        op_and,
        op_or,
        op_xor,
        op_addi,
        op_lw,
        op_sw,
        op_illegal
    } op_t;

    typedef enum logic [2:0] {
        use_old,
        load_invalid,
        load_ifid,
        load_idex,
        load_exmem,
        load_memwb
    } buffer_sel_t;

    typedef struct packed {
        logic [6:0] funct7;
        reg_idx_t   rs2;
        reg_idx_t   rs1;
        logic [2:0] funct3;
        reg_idx_t   rd;
        opcode_t    opcode;
    } r_fmt_t;

    typedef struct packed {
        logic [11:0] imm;
        reg_idx_t    rs1;
        logic [2:0]  funct3;
        reg_idx_t    rd;
        opcode_t     opcode;
    } i_fmt_t;

    typedef struct packed {
        logic [6:0] imm_hi;
        reg_idx_t   rs2;
        reg_idx_t   rs1;
        logic [2:0] funct3;
        logic [4:0] imm_lo;
        opcode_t    opcode;
    } s_fmt_t;

    typedef union packed {
        r_fmt_t r_fmt;
        i_fmt_t i_fmt;
        s_fmt_t s_fmt;
    } instr_u;

    typedef struct packed {
        op_t      op;
        reg_idx_t rs1;      // zero when the op reads no rs1.
        reg_idx_t rs2;      // zero when the op reads no rs2.
        reg_idx_t rd;
        logic     reg_we;
        logic     mem_rd;
        logic     mem_wr;
    } inst_t;

    typedef struct packed {
        logic [xlen-1:0] pc;
        instr_u          instruction;
        logic [xlen-1:0] imm;
        logic [xlen-1:0] rs1_out;
        logic [xlen-1:0] rs2_out;
        logic [xlen-1:0] alu_out;   // holds the retire value once past MEM.
        logic [xlen-1:0] mem_rdata;
    } packet_data_t;

    typedef struct packed {
        logic         valid;
        inst_t        inst;
        packet_data_t data;
    } packet_t;

    typedef struct packed {
        logic            valid;
        logic [xlen-1:0] pc;
        instr_u          instr;
    } fetch_t;

    typedef struct packed {
        logic            valid;
        logic [xlen-1:0] pc;
        reg_idx_t        rd;
        logic            reg_we;
        logic [xlen-1:0] value;
    } retire_t;

endpackage

// ==== buffer.sv ====
`timescale 1ns/1ps

module buffer (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   load,
    input  rv32i_pkg::buffer_sel_t sel,
    input  rv32i_pkg::packet_t     packet_in_old,  // previous buffer.
    input  rv32i_pkg::packet_t     packet_in_new,  // stage just finished.
    output rv32i_pkg::packet_t     packet_out
);
    import rv32i_pkg::*;

    packet_t packet;
    packet_t packet_in;

    assign packet_out = packet;

    always_ff @(posedge clk) begin
        if (rst) begin
            packet <= '0;
        end else if (load) begin
            packet <= packet_in;
        end
    end

    // start from the old packet and overlay what the stage produced.
    always_comb begin
        packet_in = packet_in_old;
        case (sel)
            use_old: begin
            end
            load_invalid: begin
                packet_in.valid = 1'b0;
            end
            load_ifid: begin
                packet_in.valid = packet_in_new.valid;
                packet_in.data.pc = packet_in_new.data.pc;
                packet_in.data.instruction = packet_in_new.data.instruction;
            end
            load_idex: begin
                packet_in.inst = packet_in_new.inst;
                packet_in.data.imm = packet_in_new.data.imm;
                packet_in.data.rs1_out = packet_in_new.data.rs1_out;
                packet_in.data.rs2_out = packet_in_new.data.rs2_out;
            end
            load_exmem: begin
                packet_in.data.alu_out = packet_in_new.data.alu_out;
            end
            load_memwb: begin
                packet_in.data.mem_rdata = packet_in_new.data.mem_rdata;
                packet_in.data.alu_out = packet_in_new.data.alu_out;  // retire value.
            end
            default: begin
                packet_in.valid = 1'b0;  // unknown code drops the packet.
            end
        endcase
    end

endmodule

// ==== regfile.sv ====
`timescale 1ns/1ps

module regfile (
    input  logic                          clk,
    input  logic                          rst,
    input  rv32i_pkg::reg_idx_t           rs1,
    input  rv32i_pkg::reg_idx_t           rs2,
    output logic [rv32i_pkg::xlen-1:0]    rs1_out,
    output logic [rv32i_pkg::xlen-1:0]    rs2_out,
    input  logic                          we,
    input  rv32i_pkg::reg_idx_t           rd,
    input  logic [rv32i_pkg::xlen-1:0]    wdata
);
    import rv32i_pkg::*;

    logic [xlen-1:0] regs [32];

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (we && rd != '0) begin
            regs[rd] <= wdata;
        end
    end

    // same-cycle write is visible to decode.
    assign rs1_out = (rs1 == '0) ? '0 : ((we && rd == rs1) ? wdata : regs[rs1]);
    assign rs2_out = (rs2 == '0) ? '0 : ((we && rd == rs2) ? wdata : regs[rs2]);

endmodule

// ==== decode.sv ====
`timescale 1ns/1ps

module decode (
    input  rv32i_pkg::instr_u          instr,
    input  logic [rv32i_pkg::xlen-1:0] rs1_out_rf,
    input  logic [rv32i_pkg::xlen-1:0] rs2_out_rf,
    output rv32i_pkg::packet_t         decoded
);
    import rv32i_pkg::*;

    op_t op;

    always_comb begin
        op = op_illegal;
        case (instr.r_fmt.opcode)
            opc_reg: begin
                case ({instr.r_fmt.funct7, instr.r_fmt.funct3})
                    10'b0000000_000: op = op_add;
                    10'b0100000_000: op = op_sub;
                    10'b0000000_100: op = op_xor;
                    10'b0000000_110: op = op_or;
                    10'b0000000_111: op = op_and;
                    default: op = op_illegal;
                endcase
            end
            opc_imm:   if (instr.i_fmt.funct3 == 3'b000) op = op_addi;
            opc_load:  if (instr.i_fmt.funct3 == 3'b010) op = op_lw;
            opc_store: if (instr.s_fmt.funct3 == 3'b010) op = op_sw;
            default:   op = op_illegal;
        endcase
    end

    always_comb begin
        decoded = '0;
        decoded.inst.op = op;
        case (op)
            op_add, op_sub, op_and, op_or, op_xor: begin
                decoded.inst.rs1 = instr.r_fmt.rs1;
                decoded.inst.rs2 = instr.r_fmt.rs2;
                decoded.inst.rd = instr.r_fmt.rd;
                decoded.inst.reg_we = 1'b1;
            end
            op_addi, op_lw: begin
                decoded.inst.rs1 = instr.i_fmt.rs1;
                decoded.inst.rd = instr.i_fmt.rd;
                decoded.inst.reg_we = 1'b1;
                decoded.inst.mem_rd = (op == op_lw);
                decoded.data.imm = {{20{instr.i_fmt.imm[11]}}, instr.i_fmt.imm};
            end
            op_sw: begin
                decoded.inst.rs1 = instr.s_fmt.rs1;
                decoded.inst.rs2 = instr.s_fmt.rs2;
                decoded.inst.mem_wr = 1'b1;
                decoded.data.imm = {{20{instr.s_fmt.imm_hi[6]}}, instr.s_fmt.imm_hi,
                                    instr.s_fmt.imm_lo};
            end
            default: begin
            end
        endcase
        decoded.data.rs1_out = rs1_out_rf;
        decoded.data.rs2_out = rs2_out_rf;
    end

endmodule

// ==== execute.sv ====
`timescale 1ns/1ps

module execute (
    input  rv32i_pkg::packet_t packet,
    output rv32i_pkg::packet_t result
);
    import rv32i_pkg::*;

    logic [xlen-1:0] a;
    logic [xlen-1:0] b;

    assign a = packet.data.rs1_out;
    assign b = packet.data.rs2_out;

    always_comb begin
        result = packet;
        case (packet.inst.op)
            op_add:  result.data.alu_out = a + b;
            op_sub:  result.data.alu_out = a - b;
            op_and:  result.data.alu_out = a & b;
            op_or:   result.data.alu_out = a | b;
            op_xor:  result.data.alu_out = a ^ b;
            // byte address for lw/sw, the memory takes bits 31:2.
            op_addi, op_lw, op_sw: begin
                result.data.alu_out = a + packet.data.imm;
            end
            default: result.data.alu_out = '0;
        endcase
    end

endmodule

// ==== data_mem.sv ====
`timescale 1ns/1ps

module data_mem #(
    parameter int MEM_WORDS = 64
) (
    input  logic               clk,
    input  logic               rst,
    input  rv32i_pkg::packet_t packet,
    input  logic               commit,
    output rv32i_pkg::packet_t result
);
    import rv32i_pkg::*;

    localparam int idx_w = (MEM_WORDS > 1) ? $clog2(MEM_WORDS) : 1;

    logic [xlen-1:0] mem [MEM_WORDS];
    logic [xlen-3:0] word_addr;
    logic [idx_w-1:0] idx;
    logic [xlen-1:0] rdata;

    assign word_addr = packet.data.alu_out[xlen-1:2];
    assign idx = idx_w'(word_addr % MEM_WORDS);  // wraps around the array.
    assign rdata = mem[idx];

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < MEM_WORDS; i++) begin
                mem[i] <= '0;
            end
        end else if (commit && packet.valid && packet.inst.mem_wr) begin
            mem[idx] <= packet.data.rs2_out;
        end
    end

    always_comb begin
        result = packet;
        result.data.mem_rdata = packet.inst.mem_rd ? rdata : '0;
        if (packet.inst.mem_rd) begin
            result.data.alu_out = rdata;
        end else if (packet.inst.mem_wr) begin
            result.data.alu_out = packet.data.rs2_out;  // sw retires its store data.
        end
    end

endmodule

// ==== mem_wait_timer.sv ====
`timescale 1ns/1ps

module mem_wait_timer #(
    parameter int MEM_LATENCY = 3
) (
    input  logic clk,
    input  logic rst,
    input  logic start,
    output logic done
);
    localparam int count_w = $clog2(MEM_LATENCY + 2);

    logic [count_w-1:0] count;

    always_ff @(posedge clk) begin
        if (rst) begin
            count <= '0;
        end else if (start) begin
            count <= count_w'(MEM_LATENCY);
        end else if (count != '0) begin
            count <= count - 1'b1;
        end
    end

    // high in the last cycle before the count hits zero.
    assign done = (count == count_w'(1));

endmodule

// ==== pipeline_control.sv ====
`timescale 1ns/1ps

module pipeline_control #(
    parameter int MEM_LATENCY = 3
) (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   fetch_valid,
    input  rv32i_pkg::packet_t     ifid,
    input  rv32i_pkg::packet_t     idex,
    input  rv32i_pkg::packet_t     exmem,
    input  logic                   mem_done,
    output rv32i_pkg::buffer_sel_t sel_ifid,
    output rv32i_pkg::buffer_sel_t sel_idex,
    output rv32i_pkg::buffer_sel_t sel_exmem,
    output rv32i_pkg::buffer_sel_t sel_memwb,
    output logic                   load_ifid,
    output logic                   load_idex,
    output logic                   load_exmem,
    output logic                   load_memwb,
    output logic                   mem_start,
    output logic                   mem_commit,
    output logic                   fetch_stall
);
    import rv32i_pkg::*;

    localparam bit mem_wait_en = (MEM_LATENCY > 0);  // zero latency needs no wait.

    typedef enum logic {
        run,
        mem_wait
    } state_t;

    state_t state;
    state_t state_next;
    logic exmem_mem;
    logic raw_hit;
    logic wait_start;
    logic freeze;

    function automatic logic pending_write(input packet_t p, input reg_idx_t r);
        return (r != '0) && p.valid && p.inst.reg_we && (p.inst.rd == r);
    endfunction

    assign exmem_mem = exmem.valid && (exmem.inst.mem_rd || exmem.inst.mem_wr);
    assign raw_hit = ifid.valid &&
                     (pending_write(idex, ifid.inst.rs1) || pending_write(exmem, ifid.inst.rs1) ||
                      pending_write(idex, ifid.inst.rs2) || pending_write(exmem, ifid.inst.rs2));

    assign wait_start = (state == run) && exmem_mem && mem_wait_en;
    assign freeze = wait_start || ((state == mem_wait) && !mem_done);
    assign mem_start = wait_start;
    assign mem_commit = (state == mem_wait) ? mem_done : (exmem_mem && !mem_wait_en);

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= run;
        end else begin
            state <= state_next;
        end
    end

    // the load_* port names shadow the enum values, hence the scoped names.
    always_comb begin
        state_next = state;
        if (fetch_valid) begin
            sel_ifid = rv32i_pkg::load_ifid;
        end else begin
            sel_ifid = load_invalid;
        end
        sel_idex = rv32i_pkg::load_idex;
        sel_exmem = rv32i_pkg::load_exmem;
        sel_memwb = rv32i_pkg::load_memwb;
        load_ifid = 1'b1;
        load_idex = 1'b1;
        load_exmem = 1'b1;
        load_memwb = 1'b1;
        fetch_stall = 1'b0;
        if (freeze) begin
            sel_ifid = use_old;
            sel_idex = use_old;
            sel_exmem = use_old;
            load_ifid = 1'b0;
            load_idex = 1'b0;
            load_exmem = 1'b0;
            sel_memwb = load_invalid;  // no retire while memory is busy.
            fetch_stall = 1'b1;
            if (wait_start) begin
                state_next = mem_wait;
            end
        end else begin
            if (raw_hit) begin
                sel_ifid = use_old;
                load_ifid = 1'b0;
                sel_idex = load_invalid;  // bubble into execute.
                fetch_stall = 1'b1;
            end
            if (state == mem_wait) begin
                state_next = run;
            end
        end
    end

endmodule

// ==== cpu_pipe.sv ====
`timescale 1ns/1ps

module cpu_pipe #(
    parameter int MEM_LATENCY = 3,
    parameter int MEM_WORDS   = 64
) (
    input  logic               clk,
    input  logic               rst,
    input  rv32i_pkg::fetch_t  fetch,
    output logic               fetch_stall,
    output rv32i_pkg::retire_t retire
);
    import rv32i_pkg::*;

    packet_t fetch_pkt;
    packet_t ifid;
    packet_t idex;
    packet_t exmem;
    packet_t memwb;
    packet_t dec_pkt;
    packet_t ifid_dec;
    packet_t ex_pkt;
    packet_t mem_pkt;
    buffer_sel_t ifid_sel;
    buffer_sel_t idex_sel;
    buffer_sel_t exmem_sel;
    buffer_sel_t memwb_sel;
    logic ifid_load;
    logic idex_load;
    logic exmem_load;
    logic memwb_load;
    logic [xlen-1:0] rs1_rf;
    logic [xlen-1:0] rs2_rf;
    logic mem_start;
    logic mem_done;
    logic mem_commit;

    always_comb begin
        fetch_pkt = '0;
        fetch_pkt.valid = fetch.valid;
        fetch_pkt.data.pc = fetch.pc;
        fetch_pkt.data.instruction = fetch.instr;
    end

    // hazard check sees the decoded registers of the ifid instruction.
    assign ifid_dec = '{valid: ifid.valid, inst: dec_pkt.inst, data: ifid.data};

    assign retire = '{valid:  memwb.valid,
                      pc:     memwb.data.pc,
                      rd:     memwb.inst.rd,
                      reg_we: memwb.inst.reg_we,
                      value:  memwb.data.alu_out};

    buffer u_ifid (.clk(clk), .rst(rst), .load(ifid_load), .sel(ifid_sel),
                   .packet_in_old(fetch_pkt), .packet_in_new(fetch_pkt), .packet_out(ifid));

    buffer u_idex (.clk(clk), .rst(rst), .load(idex_load), .sel(idex_sel),
                   .packet_in_old(ifid), .packet_in_new(dec_pkt), .packet_out(idex));

    buffer u_exmem (.clk(clk), .rst(rst), .load(exmem_load), .sel(exmem_sel),
                    .packet_in_old(idex), .packet_in_new(ex_pkt), .packet_out(exmem));

    buffer u_memwb (.clk(clk), .rst(rst), .load(memwb_load), .sel(memwb_sel),
                    .packet_in_old(exmem), .packet_in_new(mem_pkt), .packet_out(memwb));

    regfile u_rf (.clk(clk), .rst(rst), .rs1(dec_pkt.inst.rs1), .rs2(dec_pkt.inst.rs2),
                  .rs1_out(rs1_rf), .rs2_out(rs2_rf),
                  .we(memwb.valid && memwb.inst.reg_we), .rd(memwb.inst.rd),
                  .wdata(memwb.data.alu_out));

    decode u_dec (.instr(ifid.data.instruction), .rs1_out_rf(rs1_rf), .rs2_out_rf(rs2_rf),
                  .decoded(dec_pkt));

    execute u_ex (.packet(idex), .result(ex_pkt));

    data_mem #(.MEM_WORDS(MEM_WORDS)) u_dmem (
        .clk(clk), .rst(rst), .packet(exmem), .commit(mem_commit), .result(mem_pkt)
    );

    mem_wait_timer #(.MEM_LATENCY(MEM_LATENCY)) u_timer (
        .clk(clk), .rst(rst), .start(mem_start), .done(mem_done)
    );

    pipeline_control #(.MEM_LATENCY(MEM_LATENCY)) u_ctrl (
        .clk(clk),
        .rst(rst),
        .fetch_valid(fetch.valid),
        .ifid(ifid_dec),
        .idex(idex),
        .exmem(exmem),
        .mem_done(mem_done),
        .sel_ifid(ifid_sel),
        .sel_idex(idex_sel),
        .sel_exmem(exmem_sel),
        .sel_memwb(memwb_sel),
        .load_ifid(ifid_load),
        .load_idex(idex_load),
        .load_exmem(exmem_load),
        .load_memwb(memwb_load),
        .mem_start(mem_start),
        .mem_commit(mem_commit),
        .fetch_stall(fetch_stall)
    );

endmodule

// ==== cpu_pipe_props.sv ====
`timescale 1ns/1ps

module cpu_pipe_props #(
    parameter int MEM_LATENCY = 3
) (
    input logic clk,
    input logic rst,
    input logic retire_valid,
    input logic fetch_stall,
    input logic mem_start,
    input logic mem_done
);
    logic waiting;  // follows the controller's mem_wait state.

    always_ff @(posedge clk) begin
        if (rst) begin
            waiting <= 1'b0;
        end else if (mem_start) begin
            waiting <= 1'b1;
        end else if (mem_done) begin
            waiting <= 1'b0;
        end
    end

    quiet_after_reset: assert property (@(posedge clk) rst |=> !retire_valid)
        else $error("retire valid raised in the cycle after reset");

    stall_in_wait: assert property (@(posedge clk) disable iff (rst)
        waiting && !mem_done |-> fetch_stall)
        else $error("fetch_stall low while the memory access is pending");

    // the wait leaves a gap in retire, then the memory op itself retires.
    retire_gap: assert property (@(posedge clk) disable iff (rst)
        mem_start |=> (!retire_valid [*MEM_LATENCY]) ##1 retire_valid)
        else $error("retire pattern around a memory wait is wrong");

    done_latency: assert property (@(posedge clk) disable iff (rst)
        mem_start |=> (!mem_done [*MEM_LATENCY-1]) ##1 mem_done)
        else $error("mem_done did not follow mem_start after the memory latency");

endmodule

bind cpu_pipe cpu_pipe_props #(.MEM_LATENCY(MEM_LATENCY)) u_props (
    .clk(clk),
    .rst(rst),
    .retire_valid(retire.valid),
    .fetch_stall(fetch_stall),
    .mem_start(mem_start),
    .mem_done(mem_done)
);

// ==== tb_cpu_pipe.sv ====
`timescale 1ns/1ps

module tb_cpu_pipe;
    import rv32i_pkg::*;

    localparam int MEM_LATENCY = 3;
    localparam int MEM_WORDS = 64;
    localparam int n_directed = 8;
    localparam int n_random = 400;
    localparam int n_total = n_directed + n_random;
    localparam int cycle_limit = n_total * (MEM_LATENCY + 6) + 50;
    localparam int drain_limit = 4 * (MEM_LATENCY + 6);  // four buffers in flight at most.

    logic clk;
    logic rst;
    fetch_t fetch;
    logic fetch_stall;
    retire_t retire;

    integer seed;
    int errors;
    int retired;
    int cycles;
    logic [31:0] model_regs [32];
    logic [31:0] model_mem [MEM_WORDS];
    logic [31:0] directed [n_directed];
    retire_t expected_q [$];
    retire_t head;

    cpu_pipe #(.MEM_LATENCY(MEM_LATENCY), .MEM_WORDS(MEM_WORDS)) uut (
        .clk(clk), .rst(rst), .fetch(fetch), .fetch_stall(fetch_stall), .retire(retire)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    function automatic logic [31:0] r_word(input logic [6:0] funct7, input logic [2:0] funct3,
                                           input logic [4:0] rd, input logic [4:0] rs1,
                                           input logic [4:0] rs2);
        return {funct7, rs2, rs1, funct3, rd, 7'b0110011};
    endfunction

    function automatic logic [31:0] i_word(input logic [6:0] opcode, input logic [2:0] funct3,
                                           input logic [4:0] rd, input logic [4:0] rs1,
                                           input logic [11:0] imm);
        return {imm, rs1, funct3, rd, opcode};
    endfunction

    function automatic logic [31:0] s_word(input logic [4:0] rs1, input logic [4:0] rs2,
                                           input logic [11:0] imm);
        return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], 7'b0100011};
    endfunction

    // registers stay in x0..x7 so that hazards are frequent.
    function automatic logic [31:0] random_instr();
        logic [31:0] r;
        logic [31:0] w;
        logic [4:0] rd;
        logic [4:0] rs1;
        logic [4:0] rs2;
        logic [5:0] widx;
        r = $random(seed);
        w = $random(seed);
        rd = {2'b00, r[2:0]};
        rs1 = {2'b00, r[5:3]};
        rs2 = {2'b00, r[8:6]};
        widx = w[31] ? {3'b000, w[2:0]} : w[5:0];  // half the accesses hit eight hot words.
        case (r[11:9])
            3'd0: return r_word(7'b0000000, 3'b000, rd, rs1, rs2);
            3'd1: return r_word(7'b0100000, 3'b000, rd, rs1, rs2);
            3'd2: return r_word(7'b0000000, 3'b111, rd, rs1, rs2);
            3'd3: return r_word(7'b0000000, 3'b110, rd, rs1, rs2);
            3'd4: return r_word(7'b0000000, 3'b100, rd, rs1, rs2);
            3'd5: return i_word(7'b0010011, 3'b000, rd, rs1, w[11:0]);
            3'd6: return i_word(7'b0000011, 3'b010, rd, 5'd0, {4'h0, widx, 2'b00});
            default: return s_word(5'd0, rs2, {4'h0, widx, 2'b00});
        endcase
    endfunction

    // architectural model, one instruction at a time in program order.
    task automatic run_model(input logic [31:0] pc, input logic [31:0] word);
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] addr;
        retire_t entry;
        a = model_regs[word[19:15]];
        b = model_regs[word[24:20]];
        entry.valid = 1'b1;
        entry.pc = pc;
        entry.rd = word[11:7];
        entry.reg_we = 1'b1;
        entry.value = '0;
        case (word[6:0])
            7'b0110011: begin
                case ({word[31:25], word[14:12]})
                    10'b0000000_000: entry.value = a + b;
                    10'b0100000_000: entry.value = a - b;
                    10'b0000000_111: entry.value = a & b;
                    10'b0000000_110: entry.value = a | b;
                    default: entry.value = a ^ b;
                endcase
            end
            7'b0010011: entry.value = a + {{20{word[31]}}, word[31:20]};
            7'b0000011: begin
                addr = a + {{20{word[31]}}, word[31:20]};
                entry.value = model_mem[(addr >> 2) % MEM_WORDS];
            end
            default: begin
                addr = a + {{20{word[31]}}, word[31:25], word[11:7]};
                model_mem[(addr >> 2) % MEM_WORDS] = b;
                entry.rd = '0;  // a store has no destination.
                entry.reg_we = 1'b0;
                entry.value = b;
            end
        endcase
        if (entry.reg_we && entry.rd != '0) begin
            model_regs[entry.rd] = entry.value;
        end
        expected_q.push_back(entry);
    endtask

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (expected !== actual) begin
            $display("error %s: expected %h, actual %h", name, expected, actual);
            errors++;
        end
    endtask

    always @(negedge clk) begin
        if (!rst && retire.valid) begin
            if (expected_q.size() == 0) begin
                $display("retire of pc %h arrived with no instruction outstanding", retire.pc);
                errors++;
            end else begin
                head = expected_q.pop_front();
                check_value($sformatf("retire %0d pc", retired), head.pc, retire.pc);
                check_value($sformatf("retire %0d rd", retired), head.rd, retire.rd);
                check_value($sformatf("retire %0d reg_we", retired), head.reg_we, retire.reg_we);
                check_value($sformatf("retire %0d value", retired), head.value, retire.value);
                retired++;
            end
        end
    end

    initial begin
        cycles = 0;
        while (cycles < cycle_limit) begin
            @(posedge clk);
            cycles++;
        end
        $display("timeout after %0d cycles, %0d instructions outstanding, %0d errors",
                 cycles, expected_q.size(), errors);
        $display("Errors found");
        $finish;
    end

    initial begin
        logic [31:0] r;
        logic took;
        int issued;
        int drain;
        seed = 22753;
        errors = 0;
        retired = 0;
        rst = 1'b1;
        fetch = '0;
        for (int i = 0; i < 32; i++) begin
            model_regs[i] = '0;
        end
        for (int i = 0; i < MEM_WORDS; i++) begin
            model_mem[i] = '0;
        end
        directed[0] = i_word(7'b0010011, 3'b000, 5'd1, 5'd0, 12'h123);
        directed[1] = s_word(5'd0, 5'd1, 12'h008);
        directed[2] = i_word(7'b0000011, 3'b010, 5'd2, 5'd0, 12'h008);
        directed[3] = i_word(7'b0000011, 3'b010, 5'd3, 5'd0, 12'h0fc);  // untouched word.
        directed[4] = r_word(7'b0000000, 3'b000, 5'd4, 5'd2, 5'd1);
        directed[5] = i_word(7'b0010011, 3'b000, 5'd0, 5'd1, 12'h007);  // write to x0.
        directed[6] = r_word(7'b0000000, 3'b000, 5'd5, 5'd0, 5'd4);
        directed[7] = r_word(7'b0100000, 3'b000, 5'd6, 5'd5, 5'd1);

        repeat (3) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;

        // pipeline must stay quiet until the first instruction is accepted.
        repeat (2) begin
            @(negedge clk);
            check_value("idle retire valid", 1'b0, retire.valid);
            check_value("idle fetch_stall", 1'b0, fetch_stall);
        end

        issued = 0;
        took = 1'b0;
        while (issued < n_total) begin
            @(negedge clk);
            if (!fetch.valid || took) begin
                r = $random(seed);
                if (r[3:0] == 4'h0 && fetch.valid) begin
                    fetch = '0;  // drop valid for one cycle.
                end else begin
                    fetch.valid = 1'b1;
                    fetch.pc = issued * 4;
                    fetch.instr = (issued < n_directed) ? directed[issued] : random_instr();
                end
            end
            // fetch_stall only moves on the rising edge, so it is the value seen there.
            took = fetch.valid && !fetch_stall;
            if (took) begin
                run_model(fetch.pc, fetch.instr);
                issued++;
            end
        end
        @(negedge clk);
        fetch = '0;

        drain = 0;
        while (expected_q.size() != 0 && drain < drain_limit) begin
            @(posedge clk);
            drain++;
        end
        repeat (MEM_LATENCY + 6) @(posedge clk);

        if (expected_q.size() != 0) begin
            $display("%0d accepted instructions never retired", expected_q.size());
            errors++;
        end
        $display("retired %0d of %0d instructions, %0d errors", retired, n_total, errors);
        if (errors == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule

// ==== sim.f ====
rv32i_pkg.sv
buffer.sv
regfile.sv
decode.sv
execute.sv
data_mem.sv
mem_wait_timer.sv
pipeline_control.sv
cpu_pipe.sv
cpu_pipe_props.sv
tb_cpu_pipe.sv

// ==== Bender.yml ====
package:
  name: cpu_pipe

sources:
  - rv32i_pkg.sv
  - buffer.sv
  - regfile.sv
  - decode.sv
  - execute.sv
  - data_mem.sv
  - mem_wait_timer.sv
  - pipeline_control.sv
  - cpu_pipe.sv
  - target: test
    files:
      - cpu_pipe_props.sv
      - tb_cpu_pipe.sv
